//--- sram_pkg.sv
package sram_pkg;

	// External SRAM geometry.
	// 18 address bits of 16-bit words give 512 KB.
	localparam int SRAM_ADDR_W = 18;
	localparam int SRAM_DATA_W = 16;

	// APB side widths.
	localparam int APB_DATA_W = 32;
	localparam int APB_ADDR_W = 32;

	// Clock cycles spent on each SRAM half-access.
	// The write pulse sits in the middle cycles, so this must be 4 or more.
	localparam int HALF_CYCLES = 4;

	// Phase counter width, wide enough to hold HALF_CYCLES.
	localparam int TIMER_W = $clog2(HALF_CYCLES + 1);

	// Sequencer states.
	// ST_LOW and ST_HIGH are the two SRAM half-accesses of one APB word.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOW,
		ST_HIGH,
		ST_DONE,
		ST_ERROR
	} sram_state_e;

	// Transfer direction latched at the start of the access phase.
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} sram_op_e;

endpackage

//--- sram_phase_timer.sv
`timescale 1ns/1ps

module sram_phase_timer (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_run,
	output logic o_we_window,
	output logic o_capture,
	output logic o_half_end
);
	import sram_pkg::*;

	logic [TIMER_W-1:0] count;
	logic               last_cycle;

	// Final cycle of a half-access.
	assign last_cycle = (count == TIMER_W'(HALF_CYCLES - 1));

	// Counter runs 0 to HALF_CYCLES-1 and wraps, so the high half
	// follows the low half with no gap.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
		end else if (!i_run) begin
			count <= '0;
		end else if (last_cycle) begin
			count <= '0;
		end else begin
			count <= count + TIMER_W'(1);
		end
	end

	// Write enable pulse keeps off the first and last cycles,
	// which leaves address and data setup and hold around it.
	assign o_we_window = (count != '0) && (count <= TIMER_W'(HALF_CYCLES - 2));

	// Read data has had the whole half to settle by the last cycle.
	assign o_capture = last_cycle;

	assign o_half_end = last_cycle;

endmodule

//--- sram_sequencer.sv
`timescale 1ns/1ps

module sram_sequencer (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_psel,
	input  logic i_penable,
	input  logic i_pwrite,
	input  logic i_addr_ok,
	input  logic i_half_end,
	output logic o_pready,
	output logic o_pslverr,
	output logic o_timer_run,
	output logic o_half,
	output logic o_capture_en,
	output logic o_sram_ce_n,
	output logic o_sram_oe_n,
	output logic o_sram_we_en,
	output logic o_sram_dout_en
);
	import sram_pkg::*;

	sram_state_e state;
	sram_state_e state_next;
	sram_op_e    op;
	logic        access;
	logic        start;
	logic        running;
	logic        is_write;

	// APB access phase has select and enable both high.
	assign access = i_psel && i_penable;

	// New transfers are only taken from idle.
	assign start = (state == ST_IDLE) && access;

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (access) begin
					// Out of range goes straight to the error response.
					if (i_addr_ok) begin
						state_next = ST_LOW;
					end else begin
						state_next = ST_ERROR;
					end
				end
			end
			ST_LOW: begin
				if (i_half_end) begin
					state_next = ST_HIGH;
				end
			end
			ST_HIGH: begin
				if (i_half_end) begin
					state_next = ST_DONE;
				end
			end
			ST_DONE: begin
				state_next = ST_IDLE;
			end
			ST_ERROR: begin
				state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Direction is held for the whole transfer.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			op <= OP_READ;
		end else if (start) begin
			op <= i_pwrite ? OP_WRITE : OP_READ;
		end
	end

	assign running  = (state == ST_LOW) || (state == ST_HIGH);
	assign is_write = (op == OP_WRITE);

	// APB response lasts one cycle in ST_DONE or ST_ERROR.
	assign o_pready  = (state == ST_DONE) || (state == ST_ERROR);
	assign o_pslverr = (state == ST_ERROR);

	// Timer and data path control.
	assign o_timer_run  = running;
	assign o_half       = (state == ST_HIGH);
	assign o_capture_en = running && !is_write;

	// SRAM control.
	// Chip enable spans both halves so the part stays selected.
	assign o_sram_ce_n    = !running;
	assign o_sram_oe_n    = !(running && !is_write);
	assign o_sram_we_en   = running && is_write;
	assign o_sram_dout_en = running && is_write;

endmodule

//--- sram_word_path.sv
`timescale 1ns/1ps

module sram_word_path (
	input  logic                             i_clock,
	input  logic                             i_reset,
	input  logic [sram_pkg::APB_ADDR_W-1:0]  i_paddr,
	input  logic [sram_pkg::APB_DATA_W-1:0]  i_pwdata,
	input  logic [sram_pkg::APB_DATA_W/8-1:0] i_pstrb,
	input  logic                             i_half,
	input  logic                             i_we_en,
	input  logic                             i_we_window,
	input  logic                             i_capture,
	input  logic                             i_capture_en,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] i_sram_din,
	output logic                             o_addr_ok,
	output logic [sram_pkg::SRAM_ADDR_W-1:0] o_sram_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0] o_sram_dout,
	output logic                             o_sram_we_n,
	output logic                             o_sram_lb_n,
	output logic                             o_sram_ub_n,
	output logic [sram_pkg::APB_DATA_W-1:0]  o_prdata
);
	import sram_pkg::*;

	logic [1:0] lane_strb;

	// Anything above the 512 KB window is rejected.
	assign o_addr_ok = (i_paddr[APB_ADDR_W-1:SRAM_ADDR_W+1] == '0);

	// Word index from the byte address, half select as the LSB.
	assign o_sram_addr = {i_paddr[SRAM_ADDR_W:2], i_half};

	// Low half first, then high half.
	always_comb begin
		if (i_half) begin
			o_sram_dout = i_pwdata[APB_DATA_W-1:SRAM_DATA_W];
		end else begin
			o_sram_dout = i_pwdata[SRAM_DATA_W-1:0];
		end
	end

	// Strobes for the bytes of the current half.
	always_comb begin
		if (i_half) begin
			lane_strb = i_pstrb[3:2];
		end else begin
			lane_strb = i_pstrb[1:0];
		end
	end

	// Byte lanes.
	// Writes follow the strobes, reads take both bytes,
	// and the lanes stay off between transfers.
	always_comb begin
		if (i_we_en) begin
			o_sram_lb_n = !lane_strb[0];
			o_sram_ub_n = !lane_strb[1];
		end else if (i_capture_en) begin
			o_sram_lb_n = 1'b0;
			o_sram_ub_n = 1'b0;
		end else begin
			o_sram_lb_n = 1'b1;
			o_sram_ub_n = 1'b1;
		end
	end

	// SRAM stores on the rising edge of write enable, at the end of the window.
	assign o_sram_we_n = !(i_we_en && i_we_window);

	// Read halves land in their own part of the APB word.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_prdata <= '0;
		end else if (i_capture && i_capture_en) begin
			if (i_half) begin
				o_prdata[APB_DATA_W-1:SRAM_DATA_W] <= i_sram_din;
			end else begin
				o_prdata[SRAM_DATA_W-1:0] <= i_sram_din;
			end
		end
	end

endmodule

//--- apb_sram_top.sv
`timescale 1ns/1ps

module apb_sram_top (
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic                              i_psel,
	input  logic                              i_penable,
	input  logic                              i_pwrite,
	input  logic [sram_pkg::APB_ADDR_W-1:0]   i_paddr,
	input  logic [sram_pkg::APB_DATA_W-1:0]   i_pwdata,
	input  logic [sram_pkg::APB_DATA_W/8-1:0] i_pstrb,
	output logic [sram_pkg::APB_DATA_W-1:0]   o_prdata,
	output logic                              o_pready,
	output logic                              o_pslverr,
	output logic [sram_pkg::SRAM_ADDR_W-1:0]  o_sram_addr,
	output logic [sram_pkg::SRAM_DATA_W-1:0]  o_sram_dout,
	output logic                              o_sram_dout_en,
	input  logic [sram_pkg::SRAM_DATA_W-1:0]  i_sram_din,
	output logic                              o_sram_ce_n,
	output logic                              o_sram_oe_n,
	output logic                              o_sram_we_n,
	output logic                              o_sram_lb_n,
	output logic                              o_sram_ub_n
);

	logic addr_ok;
	logic half_end;
	logic timer_run;
	logic half;
	logic capture_en;
	logic sram_we_en;
	logic we_window;
	logic capture;

	sram_sequencer u_sequencer (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_psel         (i_psel),
		.i_penable      (i_penable),
		.i_pwrite       (i_pwrite),
		.i_addr_ok      (addr_ok),
		.i_half_end     (half_end),
		.o_pready       (o_pready),
		.o_pslverr      (o_pslverr),
		.o_timer_run    (timer_run),
		.o_half         (half),
		.o_capture_en   (capture_en),
		.o_sram_ce_n    (o_sram_ce_n),
		.o_sram_oe_n    (o_sram_oe_n),
		.o_sram_we_en   (sram_we_en),
		.o_sram_dout_en (o_sram_dout_en)
	);

	// One timer serves both halves.
	sram_phase_timer u_timer (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_run       (timer_run),
		.o_we_window (we_window),
		.o_capture   (capture),
		.o_half_end  (half_end)
	);

	sram_word_path u_word_path (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.i_pstrb      (i_pstrb),
		.i_half       (half),
		.i_we_en      (sram_we_en),
		.i_we_window  (we_window),
		.i_capture    (capture),
		.i_capture_en (capture_en),
		.i_sram_din   (i_sram_din),
		.o_addr_ok    (addr_ok),
		.o_sram_addr  (o_sram_addr),
		.o_sram_dout  (o_sram_dout),
		.o_sram_we_n  (o_sram_we_n),
		.o_sram_lb_n  (o_sram_lb_n),
		.o_sram_ub_n  (o_sram_ub_n),
		.o_prdata     (o_prdata)
	);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	// 8 ns period.
	initial begin
		o_clock = 1'b0;
		forever #4 o_clock = ~o_clock;
	end

	// Reset held over the first three rising edges.
	initial begin
		o_reset = 1'b1;
		repeat (3) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

//--- tb_sram_model.sv
`timescale 1ns/1ps

module tb_sram_model (
	input  logic [sram_pkg::SRAM_ADDR_W-1:0] i_addr,
	input  logic [sram_pkg::SRAM_DATA_W-1:0] i_data,
	output wire  [sram_pkg::SRAM_DATA_W-1:0] o_data,
	input  logic                             i_ce_n,
	input  logic                             i_oe_n,
	input  logic                             i_we_n,
	input  logic                             i_lb_n,
	input  logic                             i_ub_n
);
	import sram_pkg::*;

	logic [SRAM_DATA_W-1:0] mem [2**SRAM_ADDR_W];
	logic                   drive;

	// Asynchronous read with each byte lane on its own enable.
	assign drive = !i_ce_n && !i_oe_n && i_we_n;

	assign o_data[7:0]  = (drive && !i_lb_n) ? mem[i_addr][7:0] : 8'hzz;
	assign o_data[15:8] = (drive && !i_ub_n) ? mem[i_addr][15:8] : 8'hzz;

	// The part latches the bus at the end of the write pulse.
	always @(posedge i_we_n) begin
		if (!i_ce_n) begin
			if (!i_lb_n) begin
				mem[i_addr][7:0] = i_data[7:0];
			end
			if (!i_ub_n) begin
				mem[i_addr][15:8] = i_data[15:8];
			end
		end
	end

endmodule

//--- tb_apb_sram.sv
`timescale 1ns/1ps

module tb_apb_sram;
	import sram_pkg::*;

	localparam int VALID_LATENCY = 2 * HALF_CYCLES + 1;
	localparam int READY_LIMIT   = 64;
	localparam int WINDOW        = 16;

	logic                      clock;
	logic                      reset;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [APB_ADDR_W-1:0]     paddr;
	logic [APB_DATA_W-1:0]     pwdata;
	logic [APB_DATA_W/8-1:0]   pstrb;
	logic [APB_DATA_W-1:0]     prdata;
	logic                      pready;
	logic                      pslverr;
	logic [SRAM_ADDR_W-1:0]    sram_addr;
	logic [SRAM_DATA_W-1:0]    sram_dout;
	logic                      sram_dout_en;
	logic                      sram_ce_n;
	logic                      sram_oe_n;
	logic                      sram_we_n;
	logic                      sram_lb_n;
	logic                      sram_ub_n;
	wire  [SRAM_DATA_W-1:0]    sram_bus;

	logic [31:0]               rng_state;
	logic [APB_DATA_W-1:0]     ref_mem [WINDOW];
	int                        data_errors;
	int                        resp_errors;
	int                        latency_errors;
	int                        timeouts;
	logic                      aborted;

	tb_clock_gen u_clock_gen (
		.o_clock (clock),
		.o_reset (reset)
	);

	apb_sram_top u_dut (
		.i_clock        (clock),
		.i_reset        (reset),
		.i_psel         (psel),
		.i_penable      (penable),
		.i_pwrite       (pwrite),
		.i_paddr        (paddr),
		.i_pwdata       (pwdata),
		.i_pstrb        (pstrb),
		.o_prdata       (prdata),
		.o_pready       (pready),
		.o_pslverr      (pslverr),
		.o_sram_addr    (sram_addr),
		.o_sram_dout    (sram_dout),
		.o_sram_dout_en (sram_dout_en),
		.i_sram_din     (sram_bus),
		.o_sram_ce_n    (sram_ce_n),
		.o_sram_oe_n    (sram_oe_n),
		.o_sram_we_n    (sram_we_n),
		.o_sram_lb_n    (sram_lb_n),
		.o_sram_ub_n    (sram_ub_n)
	);

	// Board-level tri-state buffer on the SRAM data bus.
	assign sram_bus = sram_dout_en ? sram_dout : {SRAM_DATA_W{1'bz}};

	tb_sram_model u_sram (
		.i_addr (sram_addr),
		.i_data (sram_bus),
		.o_data (sram_bus),
		.i_ce_n (sram_ce_n),
		.i_oe_n (sram_oe_n),
		.i_we_n (sram_we_n),
		.i_lb_n (sram_lb_n),
		.i_ub_n (sram_ub_n)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Window words sit on low and high word-index bits alike.
	function automatic logic [APB_ADDR_W-1:0] window_addr(input int idx);
		logic [APB_ADDR_W-1:0] addr;
		addr = '0;
		addr[3:2] = idx[1:0];
		addr[18:17] = idx[3:2];
		return addr;
	endfunction

	function automatic logic [APB_DATA_W-1:0] merge_bytes(
		input logic [APB_DATA_W-1:0]   old_word,
		input logic [APB_DATA_W-1:0]   new_word,
		input logic [APB_DATA_W/8-1:0] strb
	);
		logic [APB_DATA_W-1:0] result;
		result = old_word;
		for (int b = 0; b < APB_DATA_W / 8; b++) begin
			if (strb[b]) begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

	task automatic check_data(input logic [APB_DATA_W-1:0] got, input logic [APB_DATA_W-1:0] exp,
		input string what);
		if (got !== exp) begin
			data_errors++;
			$display("FAILED at %0t: %s gave %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			resp_errors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		if (got != exp) begin
			latency_errors++;
			$display("FAILED at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic end_run();
		int total;
		total = data_errors + resp_errors + latency_errors + timeouts;
		$display("Errors: data %0d, response %0d, latency %0d, timeout %0d",
			data_errors, resp_errors, latency_errors, timeouts);
		if (total == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	// One APB transfer; latency counts cycles from the edge that raises penable.
	task automatic apb_transfer(
		input  logic                    write,
		input  logic [APB_ADDR_W-1:0]   addr,
		input  logic [APB_DATA_W-1:0]   wdata,
		input  logic [APB_DATA_W/8-1:0] strb,
		output logic [APB_DATA_W-1:0]   rdata,
		output logic                    err,
		output int                      latency,
		output logic                    selected
	);
		int waited;
		waited = 0;
		selected = 1'b0;
		@(posedge clock);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		pstrb   <= strb;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		while (!pready && waited < READY_LIMIT) begin
			if (!sram_ce_n) begin
				selected = 1'b1;
			end
			waited++;
			@(negedge clock);
		end
		if (!pready) begin
			timeouts++;
			aborted = 1'b1;
			$display("Timeout: no ready after %0d cycles for address %h", waited, addr);
		end else begin
			// The ready cycle itself must not select the SRAM either.
			if (!sram_ce_n) begin
				selected = 1'b1;
			end
			latency = waited;
			rdata = prdata;
			err = pslverr;
			// Completion edge.
			@(posedge clock);
			psel    <= 1'b0;
			penable <= 1'b0;
		end
	endtask

	task automatic write_word(input int idx, input logic [APB_DATA_W-1:0] data,
		input logic [APB_DATA_W/8-1:0] strb);
		logic [APB_DATA_W-1:0] rdata;
		logic                  err;
		int                    latency;
		logic                  selected;
		apb_transfer(1'b1, window_addr(idx) | (next_random() & 32'h3), data, strb,
			rdata, err, latency, selected);
		if (!aborted) begin
			check_resp(err, 1'b0, "write error response");
			check_latency(latency, VALID_LATENCY, "write latency");
			ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
		end
	endtask

	task automatic read_word(input int idx);
		logic [APB_DATA_W-1:0] rdata;
		logic                  err;
		int                    latency;
		logic                  selected;
		apb_transfer(1'b0, window_addr(idx), '0, '0, rdata, err, latency, selected);
		if (!aborted) begin
			check_resp(err, 1'b0, "read error response");
			check_latency(latency, VALID_LATENCY, "read latency");
			check_data(rdata, ref_mem[idx], $sformatf("read of window word %0d", idx));
		end
	endtask

	// Sets one of bits 31 to 19 on top of a window address.
	task automatic bad_access(input int idx, input logic write);
		logic [APB_DATA_W-1:0] rdata;
		logic                  err;
		int                    latency;
		logic                  selected;
		logic [APB_ADDR_W-1:0] addr;
		addr = window_addr(idx) | (32'h1 << (19 + next_random() % 13));
		apb_transfer(write, addr, next_random(), 4'hf, rdata, err, latency, selected);
		if (!aborted) begin
			check_resp(err, 1'b1, "out-of-range error response");
			check_latency(latency, 1, "out-of-range latency");
			check_resp(selected, 1'b0, "chip enable low in out-of-range access");
		end
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (reset !== 1'b0 && waited < 20) begin
			@(negedge clock);
			waited++;
		end
		if (reset !== 1'b0) begin
			timeouts++;
			aborted = 1'b1;
			$display("Timeout: reset was never released");
		end
	endtask

	task automatic check_reset_state();
		@(negedge clock);
		check_resp(pready, 1'b0, "o_pready after reset");
		check_resp(pslverr, 1'b0, "o_pslverr after reset");
		check_resp(sram_ce_n, 1'b1, "o_sram_ce_n after reset");
		check_resp(sram_we_n, 1'b1, "o_sram_we_n after reset");
		check_resp(sram_oe_n, 1'b1, "o_sram_oe_n after reset");
	endtask

	initial begin
		logic [31:0] r;
		int          idx;
		rng_state = 32'he6bc;
		data_errors = 0;
		resp_errors = 0;
		latency_errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		pstrb   <= '0;

		wait_reset_release();
		if (!aborted) begin
			check_reset_state();
		end

		// Known contents for every window word.
		for (int i = 0; i < WINDOW && !aborted; i++) begin
			write_word(i, next_random(), 4'hf);
		end

		// Full-word write, then read back.
		for (int i = 0; i < 4 && !aborted; i++) begin
			idx = next_random() % WINDOW;
			write_word(idx, next_random(), 4'hf);
			read_word(idx);
		end

		// Partial strobes merge into the old word.
		for (int i = 0; i < 16 && !aborted; i++) begin
			idx = next_random() % WINDOW;
			r = next_random();
			write_word(idx, next_random(), r[3:0]);
			read_word(idx);
		end

		// Out-of-range accesses leave the aliased word alone.
		for (int i = 0; i < 8 && !aborted; i++) begin
			idx = next_random() % WINDOW;
			r = next_random();
			bad_access(idx, r[0]);
			read_word(idx);
		end

		// Long random mix.
		for (int i = 0; i < 500 && !aborted; i++) begin
			r = next_random();
			idx = r[7:4];
			if (r[31:28] == 4'h0) begin
				bad_access(idx, r[8]);
			end else if (r[9]) begin
				write_word(idx, next_random(), r[3:0]);
			end else begin
				read_word(idx);
			end
		end

		end_run();
	end

endmodule

//--- verilog.f
sram_pkg.sv
sram_phase_timer.sv
sram_sequencer.sv
sram_word_path.sv
apb_sram_top.sv
tb_clock_gen.sv
tb_sram_model.sv
tb_apb_sram.sv
